// ==== src/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

  // word and port counts
  localparam int WIDTH   = 16;
  localparam int NUMRDPT = 2;   // one storage copy per read port

  // bank split of each copy
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = $clog2(NUMVBNK);
  localparam int NUMVROW = 16;
  localparam int BITVROW = $clog2(NUMVROW);

  // bank in the upper bits of the word address and row in the lower bits
  localparam int BITADDR = BITVBNK + BITVROW;

  // array pipeline depth inside a copy
  localparam int SRAM_DELAY = 2;

  // array pipeline plus the output register in rd_collect
  localparam int RD_LATENCY = SRAM_DELAY + 1;

  // one cycle per row of the clear sweep and one more for ready
  localparam int INIT_CYCLES = NUMVROW + 1;

endpackage

// ==== src/mem_types_pkg.sv ====
package mem_types_pkg;

  // init sequencer in wr_fanout
  typedef enum logic {
    INIT_CLEAR,   // sweeping rows to zero
    INIT_READY    // sweep done, requests accepted
  } init_state_t;

  // command on one copy's bank port
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_READ,
    CMD_WRITE
  } bank_cmd_t;

endpackage

// ==== src/sram_port_if.sv ====
`timescale 1ns/1ps

interface sram_port_if #(
  parameter int WIDTH   = mem_cfg_pkg::WIDTH,
  parameter int BITVBNK = mem_cfg_pkg::BITVBNK,
  parameter int BITVROW = mem_cfg_pkg::BITVROW
);

  mem_types_pkg::bank_cmd_t cmd;
  logic                     all_bnk;   // clear sweep writes every bank
  logic [BITVBNK-1:0]       bank;
  logic [BITVROW-1:0]       row;
  logic [WIDTH-1:0]         din;
  logic [WIDTH-1:0]         bw;        // per-bit write enable
  logic [WIDTH-1:0]         dout;
  logic                     dout_vld;

  modport drv (
    output cmd,
    output all_bnk,
    output bank,
    output row,
    output din,
    output bw,
    input  dout,
    input  dout_vld
  );

  modport mem (
    input  cmd,
    input  all_bnk,
    input  bank,
    input  row,
    input  din,
    input  bw,
    output dout,
    output dout_vld
  );

endinterface

// ==== src/wr_fanout.sv ====
`timescale 1ns/1ps

module wr_fanout #(
  parameter int WIDTH    = mem_cfg_pkg::WIDTH,
  parameter int NUMRDPT  = mem_cfg_pkg::NUMRDPT,
  parameter int NUMVBNK  = mem_cfg_pkg::NUMVBNK,
  parameter int NUMVROW  = mem_cfg_pkg::NUMVROW,
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITVROW = $clog2(NUMVROW),
  localparam int BITADDR = BITVBNK + BITVROW
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       write,
  input  logic [BITADDR-1:0]         wr_adr,
  input  logic [WIDTH-1:0]           din,
  input  logic [WIDTH-1:0]           bw,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic                       ready,
  sram_port_if.drv                   port_if [NUMRDPT]
);

  mem_types_pkg::init_state_t init_state;
  logic [BITVROW-1:0]         clr_row;
  logic                       clearing;
  logic                       wr_go;
  logic [BITVBNK-1:0]         wr_bank;
  logic [BITVROW-1:0]         wr_row;

  assign clearing = (init_state == mem_types_pkg::INIT_CLEAR);
  assign wr_go    = ready && write;
  assign wr_bank  = wr_adr[BITADDR-1 -: BITVBNK];
  assign wr_row   = wr_adr[BITVROW-1:0];

  // clear sweep writes one row of every bank per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      init_state <= mem_types_pkg::INIT_CLEAR;
      clr_row    <= '0;
      ready      <= 1'b0;
    end else begin
      ready <= (init_state == mem_types_pkg::INIT_READY);   // one cycle after the last row
      if (clearing) begin
        clr_row <= clr_row + BITVROW'(1);
        if (clr_row == BITVROW'(NUMVROW - 1))
          init_state <= mem_types_pkg::INIT_READY;
      end
    end
  end

  for (genvar i = 0; i < NUMRDPT; i++) begin : g_port
    logic [BITADDR-1:0] rd_word;

    assign rd_word = rd_adr[i*BITADDR +: BITADDR];

    always_ff @(posedge clk) begin
      if (rst)
        port_if[i].cmd <= mem_types_pkg::CMD_IDLE;
      else if (clearing || wr_go)
        port_if[i].cmd <= mem_types_pkg::CMD_WRITE;   // writes go to every copy
      else if (ready && read[i])
        port_if[i].cmd <= mem_types_pkg::CMD_READ;
      else
        port_if[i].cmd <= mem_types_pkg::CMD_IDLE;
    end

    always_ff @(posedge clk) begin
      if (clearing) begin
        port_if[i].all_bnk <= 1'b1;
        port_if[i].bank    <= '0;
        port_if[i].row     <= clr_row;
        port_if[i].din     <= '0;
        port_if[i].bw      <= '1;
      end else if (write) begin
        port_if[i].all_bnk <= 1'b0;
        port_if[i].bank    <= wr_bank;
        port_if[i].row     <= wr_row;
        port_if[i].din     <= din;
        port_if[i].bw      <= bw;
      end else begin
        port_if[i].all_bnk <= 1'b0;
        port_if[i].bank    <= rd_word[BITADDR-1 -: BITVBNK];
        port_if[i].row     <= rd_word[BITVROW-1:0];
      end
    end
  end

endmodule

// ==== src/read_copy.sv ====
`timescale 1ns/1ps

module read_copy #(
  parameter int WIDTH      = mem_cfg_pkg::WIDTH,
  parameter int NUMVBNK    = mem_cfg_pkg::NUMVBNK,
  parameter int NUMVROW    = mem_cfg_pkg::NUMVROW,
  parameter int SRAM_DELAY = mem_cfg_pkg::SRAM_DELAY,
  localparam int BITVBNK   = $clog2(NUMVBNK),
  localparam int BITVROW   = $clog2(NUMVROW)
) (
  input  logic    clk,
  input  logic    rst,
  sram_port_if.mem port_if
);

  logic                  wr_cmd;
  logic                  rd_cmd;
  logic [WIDTH-1:0]      bank_rd [NUMVBNK];
  logic [WIDTH-1:0]      pipe_dat [SRAM_DELAY];
  logic [SRAM_DELAY-1:0] pipe_vld;

  assign wr_cmd = (port_if.cmd == mem_types_pkg::CMD_WRITE);
  assign rd_cmd = (port_if.cmd == mem_types_pkg::CMD_READ);

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    logic [WIDTH-1:0] mem_q [NUMVROW];
    logic             bank_we;

    assign bank_we = wr_cmd && (port_if.all_bnk || port_if.bank == BITVBNK'(b));

    // bit merge under bw
    always_ff @(posedge clk) begin
      if (bank_we)
        mem_q[port_if.row] <= (mem_q[port_if.row] & ~port_if.bw) |
                              (port_if.din & port_if.bw);
    end

    assign bank_rd[b] = mem_q[port_if.row];
  end

  // valid bits of the array pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_vld <= '0;
    end else begin
      pipe_vld[0] <= rd_cmd;
      for (int s = 1; s < SRAM_DELAY; s++)
        pipe_vld[s] <= pipe_vld[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_cmd)
      pipe_dat[0] <= bank_rd[port_if.bank];   // only the addressed bank is read
    for (int s = 1; s < SRAM_DELAY; s++)
      pipe_dat[s] <= pipe_dat[s-1];
  end

  assign port_if.dout     = pipe_dat[SRAM_DELAY-1];
  assign port_if.dout_vld = pipe_vld[SRAM_DELAY-1];

endmodule

// ==== src/rd_collect.sv ====
`timescale 1ns/1ps

module rd_collect #(
  parameter int WIDTH   = mem_cfg_pkg::WIDTH,
  parameter int NUMRDPT = mem_cfg_pkg::NUMRDPT
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [WIDTH-1:0]         copy_dout [NUMRDPT],
  input  logic                     copy_vld [NUMRDPT],
  output logic [NUMRDPT-1:0]       rd_vld,
  output logic [NUMRDPT*WIDTH-1:0] rd_dout
);

  // one output lane per read port
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= '0;
    end else begin
      for (int i = 0; i < NUMRDPT; i++)
        rd_vld[i] <= copy_vld[i];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUMRDPT; i++) begin
      if (copy_vld[i])
        rd_dout[i*WIDTH +: WIDTH] <= copy_dout[i];   // hold last word otherwise
    end
  end

endmodule

// ==== src/nror1w_mem.sv ====
`timescale 1ns/1ps

module nror1w_mem #(
  parameter int WIDTH      = mem_cfg_pkg::WIDTH,
  parameter int NUMRDPT    = mem_cfg_pkg::NUMRDPT,
  parameter int NUMVBNK    = mem_cfg_pkg::NUMVBNK,
  parameter int NUMVROW    = mem_cfg_pkg::NUMVROW,
  parameter int SRAM_DELAY = mem_cfg_pkg::SRAM_DELAY,
  localparam int BITVBNK   = $clog2(NUMVBNK),
  localparam int BITVROW   = $clog2(NUMVROW),
  localparam int BITADDR   = BITVBNK + BITVROW
) (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       ready,
  input  logic                       write,
  input  logic [BITADDR-1:0]         wr_adr,
  input  logic [WIDTH-1:0]           din,
  input  logic [WIDTH-1:0]           bw,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout
);

  sram_port_if #(
    .WIDTH   (WIDTH),
    .BITVBNK (BITVBNK),
    .BITVROW (BITVROW)
  ) port_if [NUMRDPT] ();

  logic [WIDTH-1:0] copy_dout [NUMRDPT];
  logic             copy_vld [NUMRDPT];

  wr_fanout #(
    .WIDTH   (WIDTH),
    .NUMRDPT (NUMRDPT),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW)
  ) wr_fanout_i (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .ready   (ready),
    .port_if (port_if)
  );

  // one full storage copy per read port
  for (genvar i = 0; i < NUMRDPT; i++) begin : g_copy
    read_copy #(
      .WIDTH      (WIDTH),
      .NUMVBNK    (NUMVBNK),
      .NUMVROW    (NUMVROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) read_copy_i (
      .clk     (clk),
      .rst     (rst),
      .port_if (port_if[i])
    );

    assign copy_dout[i] = port_if[i].dout;
    assign copy_vld[i]  = port_if[i].dout_vld;
  end

  rd_collect #(
    .WIDTH   (WIDTH),
    .NUMRDPT (NUMRDPT)
  ) rd_collect_i (
    .clk       (clk),
    .rst       (rst),
    .copy_dout (copy_dout),
    .copy_vld  (copy_vld),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

// ==== test/nror1w_mem_asserts.sv ====
`timescale 1ns/1ps

module nror1w_mem_asserts #(
  parameter int NUMRDPT    = mem_cfg_pkg::NUMRDPT,
  parameter int SRAM_DELAY = mem_cfg_pkg::SRAM_DELAY
) (
  input logic               clk,
  input logic               rst,
  input logic               ready,
  input logic               write,
  input logic [NUMRDPT-1:0] read,
  input logic [NUMRDPT-1:0] rd_vld
);

  localparam int RD_LATENCY = SRAM_DELAY + 1;

  // single write port shares the cycle with no read
  assert property (@(posedge clk) disable iff (rst) (ready && write) |-> (read == '0))
    else $error("write and read in the same cycle");

  // ready stays up once the sweep is done
  assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else $error("ready fell outside reset");

  // rd_vld is sampled one tick after the edge that sets it
  for (genvar i = 0; i < NUMRDPT; i++) begin : g_lat
    assert property (@(posedge clk) disable iff (rst)
                     (ready && read[i]) |=> ##RD_LATENCY rd_vld[i])
      else $error("read on port %0d without rd_vld at fixed latency", i);
  end

endmodule

bind nror1w_mem nror1w_mem_asserts #(
  .NUMRDPT    (NUMRDPT),
  .SRAM_DELAY (SRAM_DELAY)
) nror1w_mem_asserts_i (
  .clk    (clk),
  .rst    (rst),
  .ready  (ready),
  .write  (write),
  .read   (read),
  .rd_vld (rd_vld)
);

// ==== test/nror1w_mem_tb.sv ====
`timescale 1ns/1ps

module nror1w_mem_tb;

  localparam int WIDTH      = mem_cfg_pkg::WIDTH;
  localparam int NUMRDPT    = mem_cfg_pkg::NUMRDPT;
  localparam int NUMVROW    = mem_cfg_pkg::NUMVROW;
  localparam int BITADDR    = mem_cfg_pkg::BITADDR;
  localparam int RD_LATENCY = mem_cfg_pkg::RD_LATENCY;

  typedef struct packed {
    logic [7:0]                 test;
    logic                       wr;
    logic [NUMRDPT-1:0]         rmask;
    logic [BITADDR-1:0]         wadr;
    logic [WIDTH-1:0]           wdat;
    logic [WIDTH-1:0]           wbw;
    logic [NUMRDPT*BITADDR-1:0] radr;
    logic [NUMRDPT*WIDTH-1:0]   exp_w;
  } row_t;

  logic                       clk;
  logic                       rst;
  logic                       ready;
  logic                       write;
  logic [BITADDR-1:0]         wr_adr;
  logic [WIDTH-1:0]           din;
  logic [WIDTH-1:0]           bw;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;

  row_t                       tbl [$];
  logic [WIDTH-1:0]           shadow [2**BITADDR];   // reference contents
  logic [NUMRDPT-1:0]         vld_q [$];
  logic [NUMRDPT*WIDTH-1:0]   word_q [$];
  integer                     seed = 8;
  int                         n_pass = 0;
  int                         n_fail = 0;
  int                         test_err = 0;
  int                         cycles = 0;
  int                         limit = 100000;

  nror1w_mem nror1w_mem_i (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
    cycles++;

  initial begin
    wait (cycles > limit);
    $display("timeout: run went past %0d cycles without finishing", limit);
    $display("TB FAILED");
    $finish;
  end

  task automatic check_word(input logic [WIDTH-1:0] got, input logic [WIDTH-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      n_fail++;
      test_err++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_vld(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      n_fail++;
      test_err++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("Fail %0t: %s after %0d cycles, expected %0d", $time, what, got, exp);
      n_fail++;
      test_err++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic add_write(input int t, input int adr, input logic [WIDTH-1:0] d,
                           input logic [WIDTH-1:0] m);
    row_t rw;
    rw       = '0;
    rw.test  = 8'(t);
    rw.wr    = 1'b1;
    rw.wadr  = BITADDR'(adr);
    rw.wdat  = d;
    rw.wbw   = m;
    shadow[adr] = (shadow[adr] & ~m) | (d & m);   // bit merge under bw
    tbl.push_back(rw);
  endtask

  task automatic add_read(input int t, input logic [1:0] mask, input int a0, input int a1,
                          input logic [WIDTH-1:0] e0, input logic [WIDTH-1:0] e1);
    row_t rw;
    rw       = '0;
    rw.test  = 8'(t);
    rw.rmask = mask;
    rw.radr  = {BITADDR'(a1), BITADDR'(a0)};
    rw.exp_w = {e1, e0};
    if ((mask[0] && shadow[a0] !== e0) || (mask[1] && shadow[a1] !== e1)) begin
      $display("table row %0d expects a word that the shadow memory does not hold",
               tbl.size());
      n_fail++;
    end
    tbl.push_back(rw);
  endtask

  task automatic add_idle(input int t, input int n);
    row_t rw;
    rw      = '0;
    rw.test = 8'(t);
    repeat (n) tbl.push_back(rw);
  endtask

  task automatic build_table();
    logic [WIDTH-1:0] r [5];
    for (int a = 0; a < 2**BITADDR; a++)
      shadow[a] = '0;
    for (int k = 0; k < 5; k++)
      r[k] = WIDTH'($random(seed));
    // zeros after the sweep even at 0x05 written while not ready
    add_read(1, 2'b11, 'h00, 'h3f, '0, '0);
    add_read(1, 2'b11, 'h05, 'h2a, '0, '0);
    add_idle(1, RD_LATENCY);
    add_write(2, 'h05, 16'ha5c3, '1);
    add_read(2, 2'b01, 'h05, 'h00, 16'ha5c3, '0);
    add_read(2, 2'b10, 'h00, 'h05, '0, 16'ha5c3);
    add_idle(2, RD_LATENCY);
    add_write(3, 'h05, 16'h1234, 16'h00ff);
    add_read(3, 2'b11, 'h05, 'h05, 16'ha534, 16'ha534);
    add_write(3, 'h05, 16'hffff, 16'hf0f0);
    add_read(3, 2'b11, 'h05, 'h05, 16'hf5f4, 16'hf5f4);
    add_idle(3, RD_LATENCY);
    add_write(4, 'h11, 16'hb00c, '1);
    add_write(4, 'h12, 16'hc0de, '1);
    add_write(4, 'h31, 16'h3131, '1);
    add_read(4, 2'b11, 'h11, 'h12, 16'hb00c, 16'hc0de);   // same bank
    add_read(4, 2'b11, 'h31, 'h11, 16'h3131, 16'hb00c);
    add_idle(4, RD_LATENCY);
    add_write(5, 'h07, r[0], '1);
    add_write(5, 'h17, r[1], '1);
    add_write(5, 'h27, r[2], '1);
    add_write(5, 'h37, r[3], '1);
    add_read(5, 2'b11, 'h07, 'h37, r[0], r[3]);
    add_read(5, 2'b11, 'h17, 'h27, r[1], r[2]);
    add_read(5, 2'b11, 'h27, 'h17, r[2], r[1]);
    add_read(5, 2'b11, 'h37, 'h07, r[3], r[0]);
    add_write(5, 'h2b, r[4], '1);
    add_read(5, 2'b11, 'h2b, 'h2b, r[4], r[4]);   // right after the write
    add_idle(5, RD_LATENCY);
  endtask

  task automatic report_test(input logic [7:0] t);
    $display("test %0d done, %0d errors", t, test_err);
    test_err = 0;
  endtask

  initial begin
    row_t               rw;
    logic [NUMRDPT-1:0] ev;
    logic [NUMRDPT*WIDTH-1:0] ew;
    logic [7:0]         cur_test;
    int                 n;
    rst    = 1'b1;
    write  = 1'b0;
    wr_adr = '0;
    din    = '0;
    bw     = '0;
    read   = '0;
    rd_adr = '0;
    build_table();
    limit = 4 + mem_cfg_pkg::INIT_CYCLES + tbl.size() + 4 * RD_LATENCY + 50;
    repeat (4) @(posedge clk);
    #2;
    rst    = 1'b0;
    write  = 1'b1;   // dropped while ready is still low
    wr_adr = BITADDR'(5);
    din    = '1;
    bw     = '1;
    read   = '1;
    rd_adr = {NUMRDPT{BITADDR'(5)}};
    n = 0;
    while (!ready) begin
      @(posedge clk);
      #1;
      n++;
      for (int i = 0; i < NUMRDPT; i++)
        check_vld(rd_vld[i], 1'b0, "rd_vld while not ready");
    end
    check_cycles(n, NUMVROW + 1, "ready rose");
    report_test(8'd6);
    repeat (RD_LATENCY) begin
      vld_q.push_back('0);
      word_q.push_back('0);
    end
    cur_test = 8'd1;
    for (int r = 0; r < tbl.size(); r++) begin
      rw = tbl[r];
      if (rw.test != cur_test) begin
        report_test(cur_test);
        cur_test = rw.test;
      end
      #1;
      write  = rw.wr;
      wr_adr = rw.wadr;
      din    = rw.wdat;
      bw     = rw.wbw;
      read   = rw.rmask;
      rd_adr = rw.radr;
      vld_q.push_back(rw.rmask);
      word_q.push_back(rw.exp_w);
      @(posedge clk);
      #1;
      ev = vld_q.pop_front();
      ew = word_q.pop_front();
      for (int i = 0; i < NUMRDPT; i++) begin
        check_vld(rd_vld[i], ev[i], $sformatf("rd_vld port %0d", i));
        if (ev[i])
          check_word(rd_dout[i*WIDTH +: WIDTH], ew[i*WIDTH +: WIDTH],
                     $sformatf("rd_dout port %0d", i));
      end
    end
    report_test(cur_test);
    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
src/mem_cfg_pkg.sv
src/mem_types_pkg.sv
src/sram_port_if.sv
src/wr_fanout.sv
src/read_copy.sv
src/rd_collect.sv
src/nror1w_mem.sv
test/nror1w_mem_asserts.sv
test/nror1w_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, pass only if the testbench reports it
verilator --binary --timing --assert -f verilog.f --top-module nror1w_mem_tb -o sim_tb &&
out=$(./obj_dir/sim_tb) ; echo "$out" &&
echo "$out" | grep -q "TB PASSED" && echo "run passed" ||
{ echo "run failed"; exit 1; }
